//--- source/core_pkg.sv
package core_pkg;

   typedef logic [31:0] xlen_t;
   typedef logic [4:0]  reg_addr_t;

   // supported machine-mode csr addresses
   typedef enum logic [11:0] {
      CSR_MSTATUS  = 12'h300,
      CSR_MISA     = 12'h301,
      CSR_MIE      = 12'h304,
      CSR_MTVEC    = 12'h305,
      CSR_MSCRATCH = 12'h340,
      CSR_MEPC     = 12'h341,
      CSR_MCAUSE   = 12'h342,
      CSR_MTVAL    = 12'h343,
      CSR_MIP      = 12'h344,
      CSR_MHARTID  = 12'hf14
   } csr_addr_t;

   typedef enum logic [2:0] {
      OP_ADDI,
      OP_CSR,
      OP_ECALL,
      OP_EBREAK,
      OP_MRET,
      OP_ILLEGAL
   } instr_op_t;

   // encoded as funct3[1:0] of the csr instructions
   typedef enum logic [1:0] {
      CSR_RW = 2'b01,
      CSR_RS = 2'b10,
      CSR_RC = 2'b11
   } csr_op_t;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_WAIT,
      ST_DECODE,
      ST_EXEC,
      ST_WRITE,
      ST_TRAP
   } ctrl_state_t;

   typedef struct packed {
      instr_op_t op;
      csr_op_t   csr_op;
      logic      use_imm;
      reg_addr_t rd;
      reg_addr_t rs1;
      xlen_t     imm;
      csr_addr_t csr_addr;
      xlen_t     raw;
   } decoded_instr_t;

   ////////////////////////////////////////
   // bit positions, masks, cause codes
   ////////////////////////////////////////
   localparam int MSTATUS_MIE_BIT  = 3;
   localparam int MSTATUS_MPIE_BIT = 7;
   localparam int IRQ_SOFT  = 3;
   localparam int IRQ_TIMER = 7;
   localparam int IRQ_EXT   = 11;

   localparam xlen_t MIE_WRITABLE = (32'd1 << IRQ_SOFT) | (32'd1 << IRQ_TIMER) | (32'd1 << IRQ_EXT);
   // rv32 with the base integer set only
   localparam xlen_t MISA_VALUE = 32'h4000_0100;

   localparam xlen_t CAUSE_ILLEGAL = 32'd2;
   localparam xlen_t CAUSE_BREAK   = 32'd3;
   localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

//--- source/csr_if.sv
`timescale 1ns/100ps

interface csr_if import core_pkg::*; ();

   // csr access, issued by the sequencer
   logic      csr_access;
   csr_addr_t csr_addr;
   csr_op_t   csr_op;
   xlen_t     csr_operand;
   xlen_t     csr_rdata;
   logic      csr_hit;

   // trap entry and return
   logic      trap_enter;
   xlen_t     trap_cause;
   xlen_t     trap_epc;
   xlen_t     trap_tval;
   logic      trap_return;
   xlen_t     trap_pc;
   xlen_t     mepc;

   // interrupt request towards the sequencer
   logic      irq_take;
   xlen_t     irq_cause;

   modport ctrl (
      output csr_access, csr_addr, csr_op, csr_operand,
      output trap_enter, trap_cause, trap_epc, trap_tval, trap_return,
      input  csr_rdata, csr_hit, irq_take, irq_cause, trap_pc, mepc
   );

   modport csr (
      input  csr_access, csr_addr, csr_op, csr_operand,
      input  trap_enter, trap_cause, trap_epc, trap_tval, trap_return,
      output csr_rdata, csr_hit, irq_take, irq_cause, trap_pc, mepc
   );

endinterface

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import core_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  start,
   input  xlen_t pc,
   output logic  fetch_req,
   output xlen_t fetch_addr,
   input  logic  fetch_ack,
   input  xlen_t fetch_data,
   output xlen_t instr_raw,
   output logic  fetch_done
);

   logic  busy;
   xlen_t addr_q;

   // a start during an open fetch is dropped
   assign fetch_req  = start && !busy;
   assign fetch_addr = busy ? addr_q : pc;

   always_ff @(posedge clk) begin
      if (rstn) begin
         busy       <= 1'b0;
         fetch_done <= 1'b0;
      end else begin
         fetch_done <= busy && fetch_ack;
         if (fetch_req) begin
            busy <= 1'b1;
         end else if (fetch_ack) begin
            busy <= 1'b0;
         end
      end
   end

   // address and returned word
   always_ff @(posedge clk) begin
      if (fetch_req) begin
         addr_q <= pc;
      end
      if (busy && fetch_ack) begin
         instr_raw <= fetch_data;
      end
   end

endmodule

//--- source/decoder.sv
`timescale 1ns/100ps

module decoder import core_pkg::*; (
   input  xlen_t          instr_raw,
   output decoded_instr_t instr,
   output reg_addr_t      rs1
);

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
   localparam xlen_t WORD_ECALL  = 32'h0000_0073;
   localparam xlen_t WORD_EBREAK = 32'h0010_0073;
   localparam xlen_t WORD_MRET   = 32'h3020_0073;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       csr_known;

   assign opcode = instr_raw[6:0];
   assign funct3 = instr_raw[14:12];
   assign rs1    = instr_raw[19:15];

   always_comb begin
      case (instr_raw[31:20])
         CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
         CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MHARTID: csr_known = 1'b1;
         default: csr_known = 1'b0;
      endcase
   end

   always_comb begin
      instr.op       = OP_ILLEGAL;
      instr.csr_op   = CSR_RW;
      instr.use_imm  = funct3[2];
      instr.rd       = instr_raw[11:7];
      instr.rs1      = instr_raw[19:15];
      instr.imm      = {{20{instr_raw[31]}}, instr_raw[31:20]};
      instr.csr_addr = csr_addr_t'(instr_raw[31:20]);
      instr.raw      = instr_raw;
      // an all-zero word stays illegal
      if (instr_raw != '0) begin
         case (opcode)
            OPC_OP_IMM: begin
               if (funct3 == 3'b000) begin
                  instr.op = OP_ADDI;
               end
            end
            OPC_SYSTEM: begin
               if (funct3 == 3'b000) begin
                  case (instr_raw)
                     WORD_ECALL:  instr.op = OP_ECALL;
                     WORD_EBREAK: instr.op = OP_EBREAK;
                     WORD_MRET:   instr.op = OP_MRET;
                     default:     instr.op = OP_ILLEGAL;
                  endcase
               end else if (funct3[1:0] != 2'b00 && csr_known) begin
                  instr.op     = OP_CSR;
                  instr.csr_op = csr_op_t'(funct3[1:0]);
               end
            end
            default: instr.op = OP_ILLEGAL;
         endcase
      end
   end

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  reg_addr_t rs1,
   output xlen_t     rs1_data,
   input  logic      wr_en,
   input  reg_addr_t wr_addr,
   input  xlen_t     wr_data
);

   xlen_t regs [32];

   // x0 is never written, so it reads zero
   assign rs1_data = regs[rs1];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_addr != '0) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

//--- source/csr_file.sv
`timescale 1ns/100ps

module csr_file import core_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic ext_intr,
   input logic software_intr,
   input logic timer_intr,
   csr_if.csr  csr
);

   logic  status_mie;
   logic  status_mpie;
   xlen_t mie;
   xlen_t mtvec;
   xlen_t mscratch;
   xlen_t mepc;
   xlen_t mcause;
   xlen_t mtval;
   xlen_t mip;
   xlen_t mstatus;
   xlen_t irq_active;
   xlen_t wval;
   xlen_t mtvec_base;
   logic  do_write;

   // mip follows the lines directly
   always_comb begin
      mip = '0;
      mip[IRQ_SOFT]  = software_intr;
      mip[IRQ_TIMER] = timer_intr;
      mip[IRQ_EXT]   = ext_intr;
      mstatus = '0;
      mstatus[MSTATUS_MIE_BIT]  = status_mie;
      mstatus[MSTATUS_MPIE_BIT] = status_mpie;
   end

   ////////////////////////////////////////
   // read and modify
   ////////////////////////////////////////
   always_comb begin
      csr.csr_hit = 1'b1;
      case (csr.csr_addr)
         CSR_MSTATUS:  csr.csr_rdata = mstatus;
         CSR_MISA:     csr.csr_rdata = MISA_VALUE;
         CSR_MIE:      csr.csr_rdata = mie;
         CSR_MTVEC:    csr.csr_rdata = mtvec;
         CSR_MSCRATCH: csr.csr_rdata = mscratch;
         CSR_MEPC:     csr.csr_rdata = mepc;
         CSR_MCAUSE:   csr.csr_rdata = mcause;
         CSR_MTVAL:    csr.csr_rdata = mtval;
         CSR_MIP:      csr.csr_rdata = mip;
         CSR_MHARTID:  csr.csr_rdata = '0;
         default: begin
            csr.csr_hit   = 1'b0;
            csr.csr_rdata = '0;
         end
      endcase
   end

   always_comb begin
      case (csr.csr_op)
         CSR_RS:  wval = csr.csr_rdata | csr.csr_operand;
         CSR_RC:  wval = csr.csr_rdata & ~csr.csr_operand;
         default: wval = csr.csr_operand;
      endcase
   end

   // set or clear with nothing to change is a pure read
   assign do_write = csr.csr_access && csr.csr_hit &&
                     (csr.csr_op == CSR_RW || csr.csr_operand != '0);

   ////////////////////////////////////////
   // interrupts and trap target
   ////////////////////////////////////////
   assign irq_active   = mip & mie;
   assign csr.irq_take = status_mie && (irq_active != '0);

   // external first, then software, then timer
   always_comb begin
      if (irq_active[IRQ_EXT]) begin
         csr.irq_cause = {1'b1, 31'(IRQ_EXT)};
      end else if (irq_active[IRQ_SOFT]) begin
         csr.irq_cause = {1'b1, 31'(IRQ_SOFT)};
      end else if (irq_active[IRQ_TIMER]) begin
         csr.irq_cause = {1'b1, 31'(IRQ_TIMER)};
      end else begin
         csr.irq_cause = '0;
      end
   end

   assign mtvec_base  = {mtvec[31:2], 2'b00};
   assign csr.trap_pc = (mtvec[1:0] == 2'b01 && csr.trap_cause[31]) ?
                        mtvec_base + {csr.trap_cause[29:0], 2'b00} : mtvec_base;
   assign csr.mepc    = mepc;

   always_ff @(posedge clk) begin
      if (rstn) begin
         status_mie  <= 1'b0;
         status_mpie <= 1'b0;
         mie         <= '0;
         mtvec       <= '0;
         mscratch    <= '0;
         mepc        <= '0;
         mcause      <= '0;
         mtval       <= '0;
      end else if (csr.trap_enter) begin
         mepc        <= csr.trap_epc;
         mcause      <= csr.trap_cause;
         mtval       <= csr.trap_tval;
         status_mpie <= status_mie;
         status_mie  <= 1'b0;
      end else if (csr.trap_return) begin
         status_mie  <= status_mpie;
         status_mpie <= 1'b1;
      end else if (do_write) begin
         case (csr.csr_addr)
            CSR_MSTATUS: begin
               status_mie  <= wval[MSTATUS_MIE_BIT];
               status_mpie <= wval[MSTATUS_MPIE_BIT];
            end
            CSR_MIE: mie <= wval & MIE_WRITABLE;
            CSR_MTVEC: begin
               // modes 2 and 3 are reserved
               if (!wval[1]) begin
                  mtvec <= wval;
               end
            end
            CSR_MSCRATCH: mscratch <= wval;
            CSR_MEPC:     mepc     <= wval;
            CSR_MCAUSE:   mcause   <= wval;
            CSR_MTVAL:    mtval    <= wval;
            // misa, mip and mhartid are read-only
            default: ;
         endcase
      end
   end

endmodule

//--- source/core_control.sv
`timescale 1ns/100ps

module core_control import core_pkg::*; #(
   parameter xlen_t RESET_PC = 32'h0000_1000
) (
   input  logic           clk,
   input  logic           rstn,
   output logic           fetch_start,
   output xlen_t          pc,
   input  xlen_t          instr_raw,
   input  logic           fetch_done,
   input  decoded_instr_t instr,
   input  xlen_t          rs1_data,
   output logic           wr_en,
   output reg_addr_t      wr_addr,
   output xlen_t          wr_data,
   output logic           retire_valid,
   output reg_addr_t      retire_rd,
   output xlen_t          retire_data,
   csr_if.ctrl            ctrl
);

   ctrl_state_t state;
   logic        wb_q;
   logic        exc_q;
   logic        ret_q;
   logic        irq_q;
   xlen_t       result_q;
   xlen_t       cause_q;
   xlen_t       tval_q;

   assign fetch_start = (state == ST_FETCH);

   // csr port
   assign ctrl.csr_access  = (state == ST_EXEC) && (instr.op == OP_CSR);
   assign ctrl.csr_addr    = instr.csr_addr;
   assign ctrl.csr_op      = instr.csr_op;
   assign ctrl.csr_operand = instr.use_imm ? {27'b0, instr.rs1} : rs1_data;

   // trap port
   // an interrupt resumes after the finished instruction
   assign ctrl.trap_enter  = (state == ST_TRAP) && !ret_q;
   assign ctrl.trap_return = (state == ST_TRAP) && ret_q;
   assign ctrl.trap_cause  = cause_q;
   assign ctrl.trap_epc    = irq_q ? pc + 32'd4 : pc;
   assign ctrl.trap_tval   = tval_q;

   // register write and trace
   assign wr_en        = (state == ST_WRITE) && wb_q && (instr.rd != '0);
   assign wr_addr      = instr.rd;
   assign wr_data      = result_q;
   assign retire_valid = wr_en;
   assign retire_rd    = instr.rd;
   assign retire_data  = result_q;

   ////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= ST_FETCH;
         pc    <= RESET_PC;
         wb_q  <= 1'b0;
         exc_q <= 1'b0;
         ret_q <= 1'b0;
         irq_q <= 1'b0;
      end else begin
         case (state)
            ST_FETCH: state <= ST_WAIT;
            ST_WAIT: begin
               if (fetch_done) begin
                  state <= ST_DECODE;
               end
            end
            ST_DECODE: begin
               wb_q  <= 1'b0;
               exc_q <= 1'b0;
               ret_q <= 1'b0;
               irq_q <= 1'b0;
               state <= ST_EXEC;
            end
            ST_EXEC: begin
               state <= ST_WRITE;
               case (instr.op)
                  OP_ADDI: begin
                     result_q <= rs1_data + instr.imm;
                     wb_q     <= 1'b1;
                  end
                  OP_CSR: begin
                     if (ctrl.csr_hit) begin
                        result_q <= ctrl.csr_rdata;
                        wb_q     <= 1'b1;
                     end else begin
                        exc_q   <= 1'b1;
                        cause_q <= CAUSE_ILLEGAL;
                        tval_q  <= instr_raw;
                     end
                  end
                  OP_ECALL: begin
                     exc_q   <= 1'b1;
                     cause_q <= CAUSE_ECALL_M;
                     tval_q  <= '0;
                  end
                  OP_EBREAK: begin
                     exc_q   <= 1'b1;
                     cause_q <= CAUSE_BREAK;
                     tval_q  <= '0;
                  end
                  OP_MRET: ret_q <= 1'b1;
                  default: begin
                     exc_q   <= 1'b1;
                     cause_q <= CAUSE_ILLEGAL;
                     tval_q  <= instr_raw;
                  end
               endcase
            end
            ST_WRITE: begin
               if (exc_q || ret_q) begin
                  state <= ST_TRAP;
               end else if (ctrl.irq_take) begin
                  irq_q   <= 1'b1;
                  cause_q <= ctrl.irq_cause;
                  tval_q  <= '0;
                  state   <= ST_TRAP;
               end else begin
                  pc    <= pc + 32'd4;
                  state <= ST_FETCH;
               end
            end
            ST_TRAP: begin
               pc    <= ret_q ? ctrl.mepc : ctrl.trap_pc;
               state <= ST_FETCH;
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

endmodule

//--- source/core_top.sv
`timescale 1ns/100ps

module core_top import core_pkg::*; #(
   parameter xlen_t RESET_PC = 32'h0000_1000
) (
   input  logic      clk,
   input  logic      rstn,
   output logic      fetch_req,
   output xlen_t     fetch_addr,
   input  logic      fetch_ack,
   input  xlen_t     fetch_data,
   input  logic      ext_intr,
   input  logic      software_intr,
   input  logic      timer_intr,
   output logic      retire_valid,
   output reg_addr_t retire_rd,
   output xlen_t     retire_data
);

   logic           fetch_start;
   xlen_t          pc;
   xlen_t          instr_raw;
   logic           fetch_done;
   decoded_instr_t instr;
   reg_addr_t      rs1;
   xlen_t          rs1_data;
   logic           wr_en;
   reg_addr_t      wr_addr;
   xlen_t          wr_data;

   csr_if csr_bus ();

   fetch_unit u_fetch (
      .clk        (clk),
      .rstn       (rstn),
      .start      (fetch_start),
      .pc         (pc),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_ack  (fetch_ack),
      .fetch_data (fetch_data),
      .instr_raw  (instr_raw),
      .fetch_done (fetch_done)
   );

   decoder u_decoder (
      .instr_raw (instr_raw),
      .instr     (instr),
      .rs1       (rs1)
   );

   reg_file u_regs (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (rs1),
      .rs1_data (rs1_data),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   csr_file u_csr (
      .clk           (clk),
      .rstn          (rstn),
      .ext_intr      (ext_intr),
      .software_intr (software_intr),
      .timer_intr    (timer_intr),
      .csr           (csr_bus.csr)
   );

   core_control #(
      .RESET_PC (RESET_PC)
   ) u_control (
      .clk          (clk),
      .rstn         (rstn),
      .fetch_start  (fetch_start),
      .pc           (pc),
      .instr_raw    (instr_raw),
      .fetch_done   (fetch_done),
      .instr        (instr),
      .rs1_data     (rs1_data),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .retire_valid (retire_valid),
      .retire_rd    (retire_rd),
      .retire_data  (retire_data),
      .ctrl         (csr_bus.ctrl)
   );

endmodule

//--- testbench/tb_core.sv
`timescale 1ns/100ps

module tb_core;

   localparam logic [31:0] RESET_PC = 32'h0000_1000;
   localparam int          TIMEOUT  = 200;

   localparam logic [2:0]  F3_RW  = 3'b001;
   localparam logic [2:0]  F3_RS  = 3'b010;
   localparam logic [2:0]  F3_RSI = 3'b110;
   localparam logic [2:0]  F3_RC  = 3'b011;
   localparam logic [11:0] A_MSTATUS  = 12'h300;
   localparam logic [11:0] A_MIE      = 12'h304;
   localparam logic [11:0] A_MTVEC    = 12'h305;
   localparam logic [11:0] A_MSCRATCH = 12'h340;
   localparam logic [11:0] A_MEPC     = 12'h341;
   localparam logic [11:0] A_MCAUSE   = 12'h342;
   localparam logic [11:0] A_MTVAL    = 12'h343;
   localparam logic [31:0] W_ECALL = 32'h0000_0073;
   localparam logic [31:0] W_MRET  = 32'h3020_0073;

   logic        clk;
   logic        rstn;
   logic        fetch_req;
   logic [31:0] fetch_addr;
   logic        fetch_ack = 1'b0;
   logic [31:0] fetch_data = 32'h0;
   logic        ext_intr;
   logic        software_intr;
   logic        timer_intr;
   logic        retire_valid;
   logic [4:0]  retire_rd;
   logic [31:0] retire_data;

   // 0x0000 to 0x1fff with handlers low and programs from RESET_PC
   logic [31:0] imem [2048];
   logic [31:0] ack_addr;
   int          ack_delay = 0;
   logic [31:0] retire_count;

   int          pass_cnt;
   int          fail_cnt;
   string       cur_test;
   string       test_msg;
   logic        test_ok;

   core_top #(
      .RESET_PC (RESET_PC)
   ) dut (
      .clk           (clk),
      .rstn          (rstn),
      .fetch_req     (fetch_req),
      .fetch_addr    (fetch_addr),
      .fetch_ack     (fetch_ack),
      .fetch_data    (fetch_data),
      .ext_intr      (ext_intr),
      .software_intr (software_intr),
      .timer_intr    (timer_intr),
      .retire_valid  (retire_valid),
      .retire_rd     (retire_rd),
      .retire_data   (retire_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // instruction memory model
   ////////////////////////////////////////
   // addi x0, x0, imm with imm folded from the address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      logic [11:0] imm;
      imm = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]} ^ {10'd0, addr[1:0]};
      return {imm, 5'd0, 3'b000, 5'd0, 7'b0010011};
   endfunction

   function automatic logic [31:0] read_word(input logic [31:0] addr);
      if (addr[31:13] == '0) begin
         return imem[addr[12:2]];
      end
      return fill_word(addr);
   endfunction

   // request sampled mid-cycle and answered two cycles later
   always begin
      @(negedge clk);
      if (rstn) begin
         ack_delay = 0;
      end else if (fetch_req) begin
         ack_addr  = fetch_addr;
         ack_delay = 2;
      end
      @(posedge clk);
      #1;
      fetch_ack = 1'b0;
      if (ack_delay != 0) begin
         ack_delay = ack_delay - 1;
         if (ack_delay == 0) begin
            fetch_ack  = 1'b1;
            fetch_data = read_word(ack_addr);
         end
      end
   end

   always @(negedge clk) begin
      if (rstn) begin
         retire_count = 32'd0;
      end else if (retire_valid) begin
         retire_count = retire_count + 32'd1;
      end
   end

   ////////////////////////////////////////
   // program building
   ////////////////////////////////////////
   function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] src, input logic [11:0] csr);
      return {csr, src, f3, rd, 7'b1110011};
   endfunction

   task automatic place_word(input logic [31:0] addr, input logic [31:0] word);
      imem[addr[12:2]] = word;
   endtask

   task automatic clear_mem();
      for (int i = 0; i < 2048; i++) begin
         imem[i] = fill_word(32'(i) << 2);
      end
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #1;
      rstn          = 1'b1;
      ext_intr      = 1'b0;
      software_intr = 1'b0;
      timer_intr    = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b0;
   endtask

   task automatic set_timer(input logic level);
      @(posedge clk);
      #1;
      timer_intr = level;
   endtask

   ////////////////////////////////////////
   // bookkeeping and waits
   ////////////////////////////////////////
   task automatic begin_test(input string name);
      cur_test = name;
      test_ok  = 1'b1;
      test_msg = "";
      clear_mem();
   endtask

   task automatic end_test();
      if (test_ok) begin
         pass_cnt++;
         $display("[PASS] %s", cur_test);
      end else begin
         fail_cnt++;
         $display("%s", test_msg);
      end
   endtask

   // only the first problem of a test is kept
   task automatic note_mismatch(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      if (test_ok) begin
         test_ok  = 1'b0;
         test_msg = $sformatf("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
                              cur_test, what, exp, act);
      end
   endtask

   task automatic note_problem(input string what);
      if (test_ok) begin
         test_ok  = 1'b0;
         test_msg = $sformatf("[FAIL] %s: %s", cur_test, what);
      end
   endtask

   task automatic wait_retire(input logic [4:0] rd, output logic [31:0] data);
      logic found;
      found = 1'b0;
      data  = 'x;
      for (int n = 0; n < TIMEOUT && !found; n++) begin
         @(negedge clk);
         if (retire_valid && retire_rd == rd) begin
            found = 1'b1;
            data  = retire_data;
         end
      end
      if (!found) begin
         note_problem($sformatf("no retire to x%0d within %0d cycles", rd, TIMEOUT));
      end
   endtask

   task automatic wait_fetch(input logic [31:0] target);
      logic found;
      found = 1'b0;
      for (int n = 0; n < TIMEOUT && !found; n++) begin
         @(negedge clk);
         found = fetch_req && fetch_addr == target;
      end
      if (!found) begin
         note_problem($sformatf("no fetch of 0x%08h within %0d cycles", target, TIMEOUT));
      end
   endtask

   task automatic next_fetch(output logic [31:0] addr);
      logic found;
      found = 1'b0;
      addr  = 'x;
      for (int n = 0; n < TIMEOUT && !found; n++) begin
         @(negedge clk);
         if (fetch_req) begin
            found = 1'b1;
            addr  = fetch_addr;
         end
      end
      if (!found) begin
         note_problem($sformatf("no fetch request within %0d cycles", TIMEOUT));
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic test_addi_chain();
      logic [31:0] val;
      begin_test("addi_chain");
      place_word(32'h1000, addi_word(5'd1, 5'd0, 12'd5));
      place_word(32'h1004, addi_word(5'd2, 5'd1, 12'd7));
      place_word(32'h1008, addi_word(5'd0, 5'd1, 12'd3));
      reset_dut();
      next_fetch(val);
      if (val !== RESET_PC) note_mismatch("first fetch", RESET_PC, val);
      wait_retire(5'd1, val);
      if (val !== 32'd5) note_mismatch("x1", 32'd5, val);
      wait_retire(5'd2, val);
      if (val !== 32'd12) note_mismatch("x2", 32'd12, val);
      // the write to x0 is done once 0x100c is fetched
      wait_fetch(32'h100c);
      if (retire_count !== 32'd2) note_mismatch("retire count", 32'd2, retire_count);
      end_test();
   endtask

   task automatic test_csr_ops();
      logic [31:0] val;
      begin_test("csr_ops");
      place_word(32'h1000, addi_word(5'd1, 5'd0, 12'h05a));
      place_word(32'h1004, csr_word(F3_RW, 5'd2, 5'd1, A_MSCRATCH));
      place_word(32'h1008, addi_word(5'd3, 5'd0, 12'h00f));
      place_word(32'h100c, csr_word(F3_RS, 5'd4, 5'd3, A_MSCRATCH));
      place_word(32'h1010, csr_word(F3_RC, 5'd6, 5'd3, A_MSCRATCH));
      place_word(32'h1014, csr_word(F3_RS, 5'd7, 5'd0, A_MSCRATCH));
      place_word(32'h1018, addi_word(5'd8, 5'd0, 12'hfff));
      place_word(32'h101c, csr_word(F3_RW, 5'd9, 5'd8, A_MIE));
      place_word(32'h1020, csr_word(F3_RSI, 5'd10, 5'd0, A_MIE));
      place_word(32'h1024, csr_word(F3_RS, 5'd11, 5'd0, A_MIE));
      reset_dut();
      wait_retire(5'd2, val);
      if (val !== 32'h0) note_mismatch("csrrw old", 32'h0, val);
      wait_retire(5'd4, val);
      if (val !== 32'h5a) note_mismatch("csrrs old", 32'h5a, val);
      wait_retire(5'd6, val);
      if (val !== 32'h5f) note_mismatch("csrrc old", 32'h5f, val);
      wait_retire(5'd7, val);
      if (val !== 32'h50) note_mismatch("mscratch", 32'h50, val);
      wait_retire(5'd9, val);
      if (val !== 32'h0) note_mismatch("mie old", 32'h0, val);
      // only msie, mtie and meie stick
      wait_retire(5'd10, val);
      if (val !== 32'h888) note_mismatch("mie", 32'h888, val);
      wait_retire(5'd11, val);
      if (val !== 32'h888) note_mismatch("mie after csrrsi", 32'h888, val);
      end_test();
   endtask

   task automatic test_ecall_mret();
      logic [31:0] val;
      begin_test("ecall_mret");
      place_word(32'h1000, addi_word(5'd1, 5'd0, 12'h400));
      place_word(32'h1004, csr_word(F3_RW, 5'd0, 5'd1, A_MTVEC));
      place_word(32'h1008, W_ECALL);
      place_word(32'h100c, addi_word(5'd5, 5'd0, 12'h033));
      place_word(32'h1010, addi_word(5'd6, 5'd0, 12'h066));
      // handler returns past the skipped word
      place_word(32'h0400, csr_word(F3_RS, 5'd2, 5'd0, A_MCAUSE));
      place_word(32'h0404, csr_word(F3_RS, 5'd3, 5'd0, A_MEPC));
      place_word(32'h0408, addi_word(5'd4, 5'd3, 12'd8));
      place_word(32'h040c, csr_word(F3_RW, 5'd0, 5'd4, A_MEPC));
      place_word(32'h0410, W_MRET);
      reset_dut();
      wait_fetch(32'h1008);
      next_fetch(val);
      if (val !== 32'h400) note_mismatch("trap fetch", 32'h400, val);
      wait_retire(5'd2, val);
      if (val !== 32'd11) note_mismatch("mcause", 32'd11, val);
      wait_retire(5'd3, val);
      if (val !== 32'h1008) note_mismatch("mepc", 32'h1008, val);
      wait_fetch(32'h0410);
      next_fetch(val);
      if (val !== 32'h1010) note_mismatch("mret fetch", 32'h1010, val);
      wait_retire(5'd6, val);
      if (val !== 32'h66) note_mismatch("x6", 32'h66, val);
      end_test();
   endtask

   task automatic test_illegal();
      logic [31:0] val;
      logic [31:0] bad_csr;
      bad_csr = csr_word(F3_RS, 5'd7, 5'd0, 12'h7c0);
      begin_test("illegal_instr");
      place_word(32'h1000, addi_word(5'd1, 5'd0, 12'h400));
      place_word(32'h1004, csr_word(F3_RW, 5'd0, 5'd1, A_MTVEC));
      // nonzero mtval so the zero word has to overwrite it
      place_word(32'h1008, csr_word(F3_RW, 5'd0, 5'd1, A_MTVAL));
      place_word(32'h100c, 32'h0);
      place_word(32'h1010, bad_csr);
      place_word(32'h1014, addi_word(5'd8, 5'd0, 12'h011));
      place_word(32'h0400, csr_word(F3_RS, 5'd2, 5'd0, A_MCAUSE));
      place_word(32'h0404, csr_word(F3_RS, 5'd3, 5'd0, A_MTVAL));
      place_word(32'h0408, csr_word(F3_RS, 5'd5, 5'd0, A_MEPC));
      place_word(32'h040c, addi_word(5'd5, 5'd5, 12'd4));
      place_word(32'h0410, csr_word(F3_RW, 5'd0, 5'd5, A_MEPC));
      place_word(32'h0414, W_MRET);
      reset_dut();
      wait_fetch(32'h100c);
      next_fetch(val);
      if (val !== 32'h400) note_mismatch("zero word trap", 32'h400, val);
      wait_retire(5'd2, val);
      if (val !== 32'd2) note_mismatch("mcause zero word", 32'd2, val);
      wait_retire(5'd3, val);
      if (val !== 32'h0) note_mismatch("mtval zero word", 32'h0, val);
      wait_fetch(32'h1010);
      next_fetch(val);
      if (val !== 32'h400) note_mismatch("bad csr trap", 32'h400, val);
      wait_retire(5'd2, val);
      if (val !== 32'd2) note_mismatch("mcause bad csr", 32'd2, val);
      wait_retire(5'd3, val);
      if (val !== bad_csr) note_mismatch("mtval bad csr", bad_csr, val);
      wait_fetch(32'h1014);
      end_test();
   endtask

   // mtvec vectored at 0x600, mie.mtie set
   task automatic irq_setup();
      place_word(32'h1000, addi_word(5'd1, 5'd0, 12'h601));
      place_word(32'h1004, csr_word(F3_RW, 5'd0, 5'd1, A_MTVEC));
      place_word(32'h1008, addi_word(5'd2, 5'd0, 12'h080));
      place_word(32'h100c, csr_word(F3_RW, 5'd0, 5'd2, A_MIE));
      place_word(32'h061c, csr_word(F3_RS, 5'd3, 5'd0, A_MCAUSE));
   endtask

   task automatic test_irq_vectored();
      logic [31:0] val;
      begin_test("timer_irq_vectored");
      irq_setup();
      place_word(32'h1010, csr_word(F3_RSI, 5'd0, 5'd8, A_MSTATUS));
      reset_dut();
      wait_fetch(32'h1014);
      set_timer(1'b1);
      next_fetch(val);
      if (val !== 32'h61c) note_mismatch("vector fetch", 32'h61c, val);
      wait_retire(5'd3, val);
      if (val !== 32'h8000_0007) note_mismatch("mcause", 32'h8000_0007, val);
      set_timer(1'b0);
      end_test();
   endtask

   task automatic test_irq_masked();
      logic [31:0] val;
      logic [31:0] exp;
      begin_test("timer_irq_masked");
      irq_setup();
      reset_dut();
      wait_fetch(32'h1010);
      set_timer(1'b1);
      for (int i = 0; i < 8; i++) begin
         exp = 32'h1014 + (32'(i) << 2);
         next_fetch(val);
         if (val !== exp) note_mismatch("sequential fetch", exp, val);
      end
      set_timer(1'b0);
      end_test();
   endtask

   initial begin
      rstn          = 1'b1;
      ext_intr      = 1'b0;
      software_intr = 1'b0;
      timer_intr    = 1'b0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      test_addi_chain();
      test_csr_ops();
      test_ecall_mret();
      test_illegal();
      test_irq_vectored();
      test_irq_masked();
      $display("tests: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- list.f
source/core_pkg.sv
source/csr_if.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/csr_file.sv
source/core_control.sv
source/core_top.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_core -f list.f
out=$(./obj_dir/Vtb_core)
echo "$out"
if echo "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
